//--- verilog.f
rtl/glb_pkg.sv
rtl/shf_pkg.sv
rtl/shf_lane.sv
rtl/shf_rd_ctrl.sv
rtl/shf_wr_ctrl.sv
rtl/shf_top.sv
dv/shf_assert.sv
dv/shf_check.sv
dv/shf_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module shf_tb -f verilog.f
	@out="$$(./obj_dir/Vshf_tb)"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

//--- dv/shf_tb.sv
// Testbench top with clock, reset, job table, buffer model, watchdog and closing report
`timescale 1ns/1ns
`default_nettype none

module shf_tb;
    import glb_pkg::*;
    import shf_pkg::*;

    // One row of the job table
    typedef struct packed {
        shf_op_e          op;
        glb_addr_t        in_base;
        glb_addr_t        out_base;
        logic [CNT_W-1:0] num;
        logic             stall;
    } job_t;

    job_t jobs [6] = '{
        '{OP_COPY, 16'h0100, 16'h2000, 16'd5,  1'b0},
        '{OP_SKEW, 16'h0040, 16'h3000, 16'd6,  1'b0},
        '{OP_SKEW, 16'h0200, 16'h3100, 16'd1,  1'b1},
        '{OP_COPY, 16'h0300, 16'h4000, 16'd12, 1'b1},
        '{OP_SKEW, 16'h0500, 16'h5000, 16'd9,  1'b1},
        // Input range wraps past the top address
        '{OP_SKEW, 16'hfffe, 16'h6000, 16'd3,  1'b0}
    };

    logic        clk = 1'b0;
    logic        rst_n;
    shf_cfg_t    cfg;
    logic        cfg_valid;
    logic        cfg_ready;
    glb_addr_t   rd_addr;
    logic        rd_addr_valid;
    logic        rd_addr_ready;
    glb_word_t   rd_data;
    logic        rd_data_valid;
    logic        rd_data_ready;
    glb_wr_t     wr;
    logic        wr_valid;
    logic        wr_ready;
    logic        done;
    int          err_cnt;
    int          job_cnt;
    int          assert_cnt;
    logic        stall_on;
    logic        stall_now;
    logic        data_taken;
    glb_addr_t   addr_q [$];
    logic [15:0] lfsr_q = 16'd46745;

    always #5 clk = ~clk;

    shf_top i_shf_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg           (cfg),
        .cfg_valid     (cfg_valid),
        .cfg_ready     (cfg_ready),
        .rd_addr       (rd_addr),
        .rd_addr_valid (rd_addr_valid),
        .rd_addr_ready (rd_addr_ready),
        .rd_data       (rd_data),
        .rd_data_valid (rd_data_valid),
        .rd_data_ready (rd_data_ready),
        .wr            (wr),
        .wr_valid      (wr_valid),
        .wr_ready      (wr_ready),
        .done          (done)
    );

    shf_check i_shf_check (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg           (cfg),
        .cfg_valid     (cfg_valid),
        .cfg_ready     (cfg_ready),
        .rd_addr       (rd_addr),
        .rd_addr_valid (rd_addr_valid),
        .rd_addr_ready (rd_addr_ready),
        .rd_data_ready (rd_data_ready),
        .wr            (wr),
        .wr_valid      (wr_valid),
        .wr_ready      (wr_ready),
        .done          (done),
        .err_cnt       (err_cnt),
        .job_cnt       (job_cnt)
    );

    assign assert_cnt = i_shf_top.i_shf_assert.fail_cnt;

    // Fibonacci LFSR, taps 16 14 13 11, one step per bit
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    // Buffer content, byte i of word a is low byte of a*4+i
    function automatic glb_word_t word_at(glb_addr_t a);
        glb_word_t w;
        for (int i = 0; i < NUM; i++) begin
            w[i*DATA_W +: DATA_W] = DATA_W'(int'(a) * 4 + i);
        end
        return w;
    endfunction

    // ============================
    // Buffer model
    // ============================

    initial begin
        rd_addr_ready = 1'b0;
        rd_data_valid = 1'b0;
        rd_data       = '0;
        wr_ready      = 1'b0;
        forever begin
            @(posedge clk);
            stall_now  = stall_on;
            data_taken = rd_data_valid && rd_data_ready;
            if (!rst_n) begin
                addr_q.delete();
            end else begin
                if (rd_addr_valid && rd_addr_ready) begin
                    addr_q.push_back(rd_addr);
                end
                if (data_taken) begin
                    void'(addr_q.pop_front());
                end
            end
            #1;
            rd_addr_ready = stall_now ? lfsr_bit() : 1'b1;
            wr_ready      = stall_now ? lfsr_bit() : 1'b1;
            // Offered data stays put until taken
            if (!rd_data_valid || data_taken) begin
                if (addr_q.size() > 0) begin
                    rd_data_valid = stall_now ? lfsr_bit() : 1'b1;
                    rd_data       = word_at(addr_q[0]);
                end else begin
                    rd_data_valid = 1'b0;
                end
            end
        end
    end

    // ============================
    // Job sequencing
    // ============================

    // Offer a job and hold it until the unit takes it
    task automatic start_job(input job_t j);
        cfg       = '{op: j.op, in_base: j.in_base, out_base: j.out_base, num: j.num};
        cfg_valid = 1'b1;
        @(posedge clk);
        while (!cfg_ready) begin
            @(posedge clk);
        end
        #1;
        // Stall pattern follows the job now running
        stall_on  = j.stall;
        cfg_valid = 1'b0;
        cfg       = '0;
    endtask

    initial begin
        rst_n     = 1'b0;
        cfg       = '0;
        cfg_valid = 1'b0;
        stall_on  = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // Next job waits on the channel until the running one is done
        for (int n = 0; n < $size(jobs); n++) begin
            start_job(jobs[n]);
        end
        @(posedge clk);
        while (!done) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        $display("Summary: %0d check errors, %0d assertion failures, %0d of %0d jobs done",
                 err_cnt, assert_cnt, job_cnt, $size(jobs));
        if (err_cnt == 0 && assert_cnt == 0 && job_cnt == $size(jobs)) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Limit scales with the total job length
    initial begin : watchdog
        int limit;
        limit = 0;
        for (int n = 0; n < $size(jobs); n++) begin
            limit += 20 * (int'(jobs[n].num) + NUM);
        end
        repeat (limit) @(posedge clk);
        $display("Timeout: jobs did not finish within %0d cycles", limit);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/shf_check.sv
// Write and done monitor that predicts each job's output from its configuration
`timescale 1ns/1ns
`default_nettype none

module shf_check (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire shf_pkg::shf_cfg_t   cfg,
    input  wire                      cfg_valid,
    input  wire                      cfg_ready,
    input  wire glb_pkg::glb_addr_t  rd_addr,
    input  wire                      rd_addr_valid,
    input  wire                      rd_addr_ready,
    input  wire                      rd_data_ready,
    input  wire glb_pkg::glb_wr_t    wr,
    input  wire                      wr_valid,
    input  wire                      wr_ready,
    input  wire                      done,
    output int                       err_cnt,
    output int                       job_cnt
);
    import glb_pkg::*;
    import shf_pkg::*;

    shf_cfg_t  job;
    logic      in_job;
    int        wr_idx;
    int        wr_total;
    int        rd_idx;
    logic      done_exp;
    glb_addr_t addr_exp;
    glb_addr_t rd_exp;
    glb_word_t data_exp;

    // Expected word j of a job
    function automatic glb_word_t expect_word(shf_cfg_t j, int idx);
        glb_word_t w;
        int        src;
        glb_addr_t a;
        w = '0;
        for (int i = 0; i < NUM; i++) begin
            // Skew delays lane i by i writes, zero outside the data
            src = (j.op == OP_SKEW) ? idx - i : idx;
            if (src >= 0 && src < int'(j.num)) begin
                a = j.in_base + glb_addr_t'(src);
                w[i*DATA_W +: DATA_W] = DATA_W'(int'(a) * 4 + i);
            end
        end
        return w;
    endfunction

    task automatic report_value(string name, logic [63:0] exp_v, logic [63:0] act_v);
        $display("Fail t=%0t %s expected %0h got %0h", $time, name, exp_v, act_v);
        err_cnt++;
    endtask

    task automatic report_event(string what);
        $display("Error t=%0t %s", $time, what);
        err_cnt++;
    endtask

    initial begin
        err_cnt  = 0;
        job_cnt  = 0;
        in_job   = 1'b0;
        wr_idx   = 0;
        wr_total = 0;
        rd_idx   = 0;
        done_exp = 1'b0;
    end

    // ============================
    // Per-cycle compare
    // ============================

    always @(posedge clk) begin
        if (rst_n) begin
            // done follows the final write by one cycle
            if (done !== done_exp) begin
                report_value("done", 64'(done_exp), 64'(done));
            end
            done_exp = 1'b0;
            if (done && in_job) begin
                in_job = 1'b0;
                job_cnt++;
            end

            if (in_job && cfg_ready && !done) begin
                report_event("cfg_ready high while a job is running");
            end
            if (!in_job && rd_addr_valid) begin
                report_event("read address issued with no job running");
            end
            if (!in_job && rd_data_ready) begin
                report_event("read data ready raised with no job running");
            end

            // Read addresses walk up from the input base
            if (in_job && rd_addr_valid && rd_addr_ready) begin
                if (rd_idx >= int'(job.num)) begin
                    report_event("more read addresses than words in the job");
                end else begin
                    rd_exp = job.in_base + glb_addr_t'(rd_idx);
                    if (rd_addr !== rd_exp) begin
                        report_value("rd_addr", 64'(rd_exp), 64'(rd_addr));
                    end
                end
                rd_idx++;
            end

            if (wr_valid && wr_ready) begin
                if (!in_job || wr_idx >= wr_total) begin
                    report_event("write outside the expected job sequence");
                end else begin
                    addr_exp = job.out_base + glb_addr_t'(wr_idx);
                    data_exp = expect_word(job, wr_idx);
                    if (wr.addr !== addr_exp) begin
                        report_value("wr.addr", 64'(addr_exp), 64'(wr.addr));
                    end
                    if (wr.data !== data_exp) begin
                        report_value("wr.data", 64'(data_exp), 64'(wr.data));
                    end
                    if (wr_idx == wr_total - 1) begin
                        done_exp = 1'b1;
                    end
                    wr_idx++;
                end
            end

            // New job, skew adds the flush tail
            if (cfg_valid && cfg_ready) begin
                job      = cfg;
                in_job   = 1'b1;
                wr_idx   = 0;
                rd_idx   = 0;
                wr_total = int'(cfg.num) + ((cfg.op == OP_SKEW) ? NUM - 1 : 0);
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/shf_assert.sv
// Concurrent handshake assertions for the shift unit top, bound into shf_top
`timescale 1ns/1ns
`default_nettype none

module shf_assert (
    input wire                      clk,
    input wire                      rst_n,
    input wire shf_pkg::shf_cfg_t   cfg,
    input wire                      cfg_valid,
    input wire                      cfg_ready,
    input wire glb_pkg::glb_addr_t  rd_addr,
    input wire                      rd_addr_valid,
    input wire                      rd_addr_ready,
    input wire glb_pkg::glb_word_t  rd_data,
    input wire                      rd_data_valid,
    input wire                      rd_data_ready,
    input wire glb_pkg::glb_wr_t    wr,
    input wire                      wr_valid,
    input wire                      wr_ready,
    input wire                      done
);
    import glb_pkg::*;
    import shf_pkg::*;

    // Failure tally, read by the testbench
    int fail_cnt = 0;

    // ============================
    // Payload hold while waiting
    // ============================

    a_cfg_hold: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_valid && !cfg_ready |=> cfg_valid && $stable(cfg))
        else begin
            fail_cnt++;
            $error("configuration dropped or changed before acceptance");
        end

    a_rd_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rd_addr_valid && !rd_addr_ready |=> rd_addr_valid && $stable(rd_addr))
        else begin
            fail_cnt++;
            $error("read address dropped or changed before acceptance");
        end

    a_rd_data_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rd_data_valid && !rd_data_ready |=> rd_data_valid && $stable(rd_data))
        else begin
            fail_cnt++;
            $error("read data dropped or changed before acceptance");
        end

    a_wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wr_valid && !wr_ready |=> wr_valid && $stable(wr))
        else begin
            fail_cnt++;
            $error("write dropped or changed before acceptance");
        end

    // ============================
    // Job framing
    // ============================

    // Idle unit has nothing to write
    a_no_idle_wr: assert property (@(posedge clk) disable iff (!rst_n)
        wr_valid |-> !cfg_ready)
        else begin
            fail_cnt++;
            $error("write offered while the unit is idle");
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else begin
            fail_cnt++;
            $error("done held high for two cycles");
        end

endmodule

bind shf_top shf_assert i_shf_assert (
    .clk           (clk),
    .rst_n         (rst_n),
    .cfg           (cfg),
    .cfg_valid     (cfg_valid),
    .cfg_ready     (cfg_ready),
    .rd_addr       (rd_addr),
    .rd_addr_valid (rd_addr_valid),
    .rd_addr_ready (rd_addr_ready),
    .rd_data       (rd_data),
    .rd_data_valid (rd_data_valid),
    .rd_data_ready (rd_data_ready),
    .wr            (wr),
    .wr_valid      (wr_valid),
    .wr_ready      (wr_ready),
    .done          (done)
);

`default_nettype wire

//--- rtl/shf_top.sv
// Shift unit top joining read controller, byte lanes and write controller
`timescale 1ns/1ns
`default_nettype none

module shf_top (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire shf_pkg::shf_cfg_t    cfg,
    input  wire                       cfg_valid,
    output logic                      cfg_ready,
    output glb_pkg::glb_addr_t        rd_addr,
    output logic                      rd_addr_valid,
    input  wire                       rd_addr_ready,
    input  wire glb_pkg::glb_word_t   rd_data,
    input  wire                       rd_data_valid,
    output logic                      rd_data_ready,
    output glb_pkg::glb_wr_t          wr,
    output logic                      wr_valid,
    input  wire                       wr_ready,
    output logic                      done
);
    import glb_pkg::*;
    import shf_pkg::*;

    shf_step_t step;
    logic      step_valid;
    logic      step_ready;
    logic      step_fire;
    shf_op_e   op;
    glb_addr_t out_base;
    logic      lane_clear;
    logic      job_end;
    glb_word_t lane_bytes;

    // All lanes advance together
    assign step_fire = step_valid & step_ready;

    shf_rd_ctrl u_rd_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg           (cfg),
        .cfg_valid     (cfg_valid),
        .cfg_ready     (cfg_ready),
        .rd_addr       (rd_addr),
        .rd_addr_valid (rd_addr_valid),
        .rd_addr_ready (rd_addr_ready),
        .rd_data       (rd_data),
        .rd_data_valid (rd_data_valid),
        .rd_data_ready (rd_data_ready),
        .step          (step),
        .step_valid    (step_valid),
        .step_ready    (step_ready),
        .op            (op),
        .out_base      (out_base),
        .lane_clear    (lane_clear),
        .job_end       (job_end)
    );

    // ============================
    // Byte lanes
    // ============================

    for (genvar i = 0; i < NUM; i++) begin : g_lane
        shf_lane #(
            .LANE (i)
        ) u_lane (
            .clk   (clk),
            .rst_n (rst_n),
            .clear (lane_clear),
            .op    (op),
            .shift (step_fire),
            .din   (step.word[i*DATA_W +: DATA_W]),
            .dout  (lane_bytes[i*DATA_W +: DATA_W])
        );
    end

    shf_wr_ctrl u_wr_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .lane_bytes (lane_bytes),
        .step_fire  (step_fire),
        .step_last  (step.last),
        .out_base   (out_base),
        .step_ready (step_ready),
        .wr         (wr),
        .wr_valid   (wr_valid),
        .wr_ready   (wr_ready),
        .job_end    (job_end),
        .done       (done)
    );

endmodule

`default_nettype wire

//--- rtl/shf_wr_ctrl.sv
// Output word register, write address counter, job end and done pulse
`timescale 1ns/1ns
`default_nettype none

module shf_wr_ctrl (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire glb_pkg::glb_word_t   lane_bytes,
    input  wire                       step_fire,
    input  wire                       step_last,
    input  wire glb_pkg::glb_addr_t   out_base,
    output logic                      step_ready,
    output glb_pkg::glb_wr_t          wr,
    output logic                      wr_valid,
    input  wire                       wr_ready,
    output logic                      job_end,
    output logic                      done
);
    import glb_pkg::*;

    glb_word_t word_q;
    logic      vld_q;
    logic      last_q;
    glb_addr_t wr_cnt;
    logic      wr_fire;

    // ============================
    // Output register handshake
    // ============================

    // Room when empty or emptying this cycle
    assign step_ready = ~vld_q | wr_ready;
    assign wr_fire    = vld_q & wr_ready;
    assign wr_valid   = vld_q;

    // Address follows the write count within the job
    assign wr = '{addr: out_base + wr_cnt, data: word_q};

    // Final write of the job leaves
    assign job_end = wr_fire & last_q;

    always_ff @(posedge clk) begin
        if (step_fire) begin
            word_q <= lane_bytes;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q  <= 1'b0;
            last_q <= 1'b0;
        end else if (step_fire) begin
            vld_q  <= 1'b1;
            last_q <= step_last;
        end else if (wr_fire) begin
            vld_q  <= 1'b0;
            last_q <= 1'b0;
        end
    end

    // ============================
    // Write count and done
    // ============================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_cnt <= '0;
        end else if (wr_fire) begin
            // Restart for the next job
            wr_cnt <= job_end ? '0 : wr_cnt + 1'b1;
        end
    end

    // One cycle after the last write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= job_end;
        end
    end

endmodule

`default_nettype wire

//--- rtl/shf_rd_ctrl.sv
// Job FSM, configuration capture, read address issue and lane step sequencing with flush
`timescale 1ns/1ns
`default_nettype none

module shf_rd_ctrl (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire shf_pkg::shf_cfg_t    cfg,
    input  wire                       cfg_valid,
    output logic                      cfg_ready,
    output glb_pkg::glb_addr_t        rd_addr,
    output logic                      rd_addr_valid,
    input  wire                       rd_addr_ready,
    input  wire glb_pkg::glb_word_t   rd_data,
    input  wire                       rd_data_valid,
    output logic                      rd_data_ready,
    output shf_pkg::shf_step_t        step,
    output logic                      step_valid,
    input  wire                       step_ready,
    output shf_pkg::shf_op_e          op,
    output glb_pkg::glb_addr_t        out_base,
    output logic                      lane_clear,
    input  wire                       job_end
);
    import glb_pkg::*;
    import shf_pkg::*;

    shf_state_e        state;
    shf_state_e        state_nxt;
    shf_cfg_t          cfg_q;
    glb_addr_t         a_cnt;
    logic [STEP_W-1:0] s_cnt;
    logic [STEP_W-1:0] step_total;
    logic              cfg_fire;
    logic              addr_fire;
    logic              step_fire;
    logic              data_open;
    logic              data_last;

    // ============================
    // Configuration
    // ============================

    // Accept a new job only when idle
    assign cfg_ready  = (state == ST_IDLE);
    assign cfg_fire   = cfg_valid & cfg_ready;
    // Zero the delay lines on the accepting edge
    assign lane_clear = cfg_fire;
    assign op         = cfg_q.op;
    assign out_base   = cfg_q.out_base;

    always_ff @(posedge clk) begin
        if (cfg_fire) begin
            cfg_q <= cfg;
        end
    end

    // ============================
    // Read address stream
    // ============================

    // Runs ahead of the data, one address per accepted cycle
    assign rd_addr_valid = (state == ST_READ) && (a_cnt < cfg_q.num);
    assign rd_addr       = cfg_q.in_base + a_cnt;
    assign addr_fire     = rd_addr_valid & rd_addr_ready;

    // ============================
    // Step stream
    // ============================

    // Skew jobs append the flush tail
    assign step_total = STEP_W'(cfg_q.num) + ((cfg_q.op == OP_SKEW) ? STEP_W'(SKEW_DEPTH) : '0);
    // Still expecting buffer data
    assign data_open  = (s_cnt < STEP_W'(cfg_q.num));
    assign data_last  = (s_cnt == STEP_W'(cfg_q.num) - 1'b1);
    assign step_fire  = step_valid & step_ready;

    always_comb begin
        step_valid    = 1'b0;
        rd_data_ready = 1'b0;
        step.word     = '0;
        step.last     = (s_cnt == step_total - 1'b1);
        case (state)
            ST_READ: begin
                // Data word passes straight through as a step
                step_valid    = rd_data_valid & data_open;
                rd_data_ready = step_ready & data_open;
                step.word     = rd_data;
            end
            ST_FLUSH: begin
                // Zero words push the tail out of the delay lines
                step_valid = (s_cnt < step_total);
            end
            default: begin
                step_valid = 1'b0;
            end
        endcase
    end

    // ============================
    // FSM
    // ============================

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (cfg_fire) begin
                    state_nxt = ST_READ;
                end
            end
            ST_READ: begin
                // Copy jobs wait here for the final write
                if (job_end) begin
                    state_nxt = ST_IDLE;
                end else if (step_fire && data_last && cfg_q.op == OP_SKEW) begin
                    state_nxt = ST_FLUSH;
                end
            end
            ST_FLUSH: begin
                if (job_end) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            a_cnt <= '0;
            s_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (cfg_fire) begin
                a_cnt <= '0;
                s_cnt <= '0;
            end else begin
                if (addr_fire) begin
                    a_cnt <= a_cnt + 1'b1;
                end
                if (step_fire) begin
                    s_cnt <= s_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/shf_lane.sv
// Single byte lane with a delay line and an opcode-selected tap
`timescale 1ns/1ns
`default_nettype none

module shf_lane #(
    parameter int LANE = 0
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         clear,
    input  wire shf_pkg::shf_op_e       op,
    input  wire                         shift,
    input  wire [glb_pkg::DATA_W-1:0]   din,
    output logic [glb_pkg::DATA_W-1:0]  dout
);
    import glb_pkg::*;
    import shf_pkg::*;

    logic [DATA_W-1:0] dly [SKEW_DEPTH];

    // Delay line, stage k holds the byte from k+1 steps ago
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < SKEW_DEPTH; k++) begin
                dly[k] <= '0;
            end
        end else if (clear) begin
            // New job starts from an empty triangle
            for (int k = 0; k < SKEW_DEPTH; k++) begin
                dly[k] <= '0;
            end
        end else if (shift) begin
            dly[0] <= din;
            for (int k = 1; k < SKEW_DEPTH; k++) begin
                dly[k] <= dly[k-1];
            end
        end
    end

    // Lane 0 is never delayed
    if (LANE == 0) begin : g_tap_direct
        assign dout = din;
    end else begin : g_tap_delay
        // Copy jobs bypass the delay line
        assign dout = (op == OP_COPY) ? din : dly[LANE-1];
    end

endmodule

`default_nettype wire

//--- rtl/shf_pkg.sv
// Shift unit opcode and state enums, configuration struct and lane step struct
`default_nettype none

package shf_pkg;

    // ============================
    // Sizes
    // ============================

    // Word count field width
    localparam int CNT_W = 16;

    // Step counter needs one extra bit for the flush tail
    localparam int STEP_W = CNT_W + 1;

    // Deepest lane delay, also the number of flush steps
    localparam int SKEW_DEPTH = glb_pkg::NUM - 1;

    // ============================
    // Enums
    // ============================

    typedef enum logic {
        OP_COPY = 1'b0,
        OP_SKEW = 1'b1
    } shf_op_e;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_READ  = 2'd1,
        ST_FLUSH = 2'd2
    } shf_state_e;

    // ============================
    // Structs
    // ============================

    // Job description, 49 bits
    typedef struct packed {
        shf_op_e           op;
        glb_pkg::glb_addr_t in_base;
        glb_pkg::glb_addr_t out_base;
        logic [CNT_W-1:0]  num;
    } shf_cfg_t;

    // One lane advance, 33 bits
    typedef struct packed {
        glb_pkg::glb_word_t word;
        logic               last;
    } shf_step_t;

endpackage

`default_nettype wire

//--- rtl/glb_pkg.sv
// Global buffer word, address and byte-lane constants plus the write request struct
`default_nettype none

package glb_pkg;

    // ============================
    // Buffer geometry
    // ============================

    // Address width of the GLB
    localparam int GLB_ADDR_W = 16;

    // One byte per lane
    localparam int DATA_W = 8;

    // Byte lanes per buffer word, fixed by the word format
    localparam int NUM = 4;
    localparam int WORD_W = DATA_W * NUM;

    // ============================
    // Bus types
    // ============================

    typedef logic [GLB_ADDR_W-1:0] glb_addr_t;

    // Byte i sits in bits [i*DATA_W +: DATA_W]
    typedef logic [WORD_W-1:0] glb_word_t;

    // Write request, 48 bits
    typedef struct packed {
        glb_addr_t addr;
        glb_word_t data;
    } glb_wr_t;

endpackage

`default_nettype wire
